//--- logic/lsu_pkg.sv
// load/store unit shared types
package lsu_pkg;

   // word memory geometry
   localparam int RAM_AW    = 8;              // 256 words, byte addresses wrap at 1024
   localparam int RAM_WORDS = 1 << RAM_AW;

   // memory busy timing
   localparam int RAM_LAT    = 3;             // busy cycles of a plain access
   localparam int RAM_JITTER = 2;             // added on every second access
   localparam int RAM_CW     = $clog2(RAM_LAT + RAM_JITTER + 1);

   // load funct3 codes
   localparam logic [2:0] F3_LB  = 3'd0;
   localparam logic [2:0] F3_LH  = 3'd1;
   localparam logic [2:0] F3_LW  = 3'd2;
   localparam logic [2:0] F3_LBU = 3'd4;
   localparam logic [2:0] F3_LHU = 3'd5;

   // stores reuse the size codes 0 to 2
   // everything else is reserved

   // access width, low two bits of funct3
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } access_size_t;

   // one decoded access
   // lo lanes go to word_addr, hi lanes to word_addr + 1
   typedef struct packed {
      access_size_t      size;
      logic              is_unsigned;    // funct3 bit 2
      logic [1:0]        offset;         // byte address bits 1:0
      logic [RAM_AW-1:0] word_addr;      // first word index
      logic              split;          // crosses into the next word
      logic [3:0]        mask_lo;
      logic [3:0]        mask_hi;
      logic [31:0]       data_lo;
      logic [31:0]       data_hi;
   } access_t;

endpackage

//--- logic/mem_word_if.sv
`timescale 1ns/1ns
// word memory handshake
interface mem_word_if import lsu_pkg::*; ();

   logic              rd;        // read request, single cycle
   logic              we;        // write request, single cycle
   logic [RAM_AW-1:0] addr;      // word index
   logic [31:0]       wdata;
   logic [3:0]        mask;      // byte enables of wdata
   logic              busy;      // rises the cycle after a request
   logic [31:0]       rdata;     // valid once busy drops again

   // request side
   modport sequencer (
      output rd, we, addr, wdata, mask,
      input  busy, rdata
   );

   // memory side
   modport memory (
      input  rd, we, addr, wdata, mask,
      output busy, rdata
   );

endinterface

//--- logic/access_decode.sv
`timescale 1ns/1ns
// access decode stage
module access_decode import lsu_pkg::*; (
   input  logic [2:0]  i_funct,
   input  logic [31:0] i_addr,
   input  logic [31:0] i_wdata,
   output access_t     o_acc,
   output logic        o_illegal
);

   access_size_t size;
   logic [2:0]   nbytes;
   logic [3:0]   size_mask;
   logic [1:0]   offset;
   logic [7:0]   mask_win;     // byte lanes of the two-word window
   logic [63:0]  data_win;

   // size and sign from funct3
   always_comb begin
      size      = SZ_WORD;
      nbytes    = 3'd4;
      size_mask = 4'b1111;
      o_illegal = 1'b0;
      case (i_funct)
         F3_LB, F3_LBU: begin
            size      = SZ_BYTE;
            nbytes    = 3'd1;
            size_mask = 4'b0001;
         end
         F3_LH, F3_LHU: begin
            size      = SZ_HALF;
            nbytes    = 3'd2;
            size_mask = 4'b0011;
         end
         F3_LW: begin
            size      = SZ_WORD;
         end
         default: begin
            o_illegal = 1'b1;    // 3, 6 and 7
         end
      endcase
   end

   assign offset = i_addr[1:0];

   // place mask and data at the byte offset
   assign mask_win = {4'b0000, size_mask} << offset;
   assign data_win = {32'h0000_0000, i_wdata} << {offset, 3'b000};

   assign o_acc.size        = size;
   assign o_acc.is_unsigned = i_funct[2];
   assign o_acc.offset      = offset;
   assign o_acc.word_addr   = i_addr[RAM_AW+1:2];
   assign o_acc.split       = ({1'b0, offset} + nbytes) > 3'd4;  // spills past byte 3
   assign o_acc.mask_lo     = mask_win[3:0];
   assign o_acc.mask_hi     = mask_win[7:4];
   assign o_acc.data_lo     = data_win[31:0];
   assign o_acc.data_hi     = data_win[63:32];

endmodule

//--- logic/access_sequencer.sv
`timescale 1ns/1ns
// access sequencer and APB ready timing
module access_sequencer import lsu_pkg::*; (
   input  logic          clk,
   input  logic          rst_x,
   input  logic          i_psel,
   input  logic          i_penable,
   input  logic          i_pwrite,
   input  access_t       i_acc,
   input  logic          i_illegal,
   output logic          o_pready,
   output logic          o_pslverr,
   output access_t       o_acc_q,
   output logic [31:0]   o_rword_lo,
   output logic [31:0]   o_rword_hi,
   mem_word_if.sequencer mem
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,          // request is on the bus
      ST_WAIT,         // memory busy
      ST_DONE          // pready cycle
   } state_t;

   state_t state_q;
   logic   write_q;
   logic   second_q;   // second word of a split access
   logic   setup;
   logic   reject;
   logic   word_done;

   assign setup     = i_psel && !i_penable;
   // store funct3 has no unsigned forms
   assign reject    = i_illegal || (i_pwrite && i_acc.is_unsigned);
   assign word_done = (state_q == ST_WAIT) && !mem.busy;

   // control FSM
   always_ff @(posedge clk) begin
      if (!rst_x) begin
         state_q   <= ST_IDLE;
         write_q   <= 1'b0;
         second_q  <= 1'b0;
         o_pready  <= 1'b0;
         o_pslverr <= 1'b0;
         mem.rd    <= 1'b0;
         mem.we    <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (setup) begin
                  write_q  <= i_pwrite;
                  second_q <= 1'b0;
                  if (reject) begin
                     o_pready  <= 1'b1;    // error ends the first access cycle
                     o_pslverr <= 1'b1;
                     state_q   <= ST_DONE;
                  end else begin
                     mem.rd  <= !i_pwrite;
                     mem.we  <= i_pwrite;
                     state_q <= ST_REQ;
                  end
               end
            end
            ST_REQ: begin
               mem.rd  <= 1'b0;
               mem.we  <= 1'b0;
               state_q <= ST_WAIT;
            end
            ST_WAIT: begin
               if (!mem.busy) begin
                  if (o_acc_q.split && !second_q) begin
                     second_q <= 1'b1;
                     mem.rd   <= !write_q;
                     mem.we   <= write_q;
                     state_q  <= ST_REQ;
                  end else begin
                     o_pready <= 1'b1;
                     state_q  <= ST_DONE;
                  end
               end
            end
            default: begin
               o_pready  <= 1'b0;
               o_pslverr <= 1'b0;
               state_q   <= ST_IDLE;
            end
         endcase
      end
   end

   // access capture, memory request payload and read words
   always_ff @(posedge clk) begin
      if ((state_q == ST_IDLE) && setup) begin
         o_acc_q   <= i_acc;
         mem.addr  <= i_acc.word_addr;
         mem.wdata <= i_acc.data_lo;
         mem.mask  <= i_acc.mask_lo;
      end else if (word_done && !second_q) begin
         o_rword_lo <= mem.rdata;
         mem.addr   <= o_acc_q.word_addr + 1'b1;   // wraps to word 0
         mem.wdata  <= o_acc_q.data_hi;
         mem.mask   <= o_acc_q.mask_hi;
      end
      if (word_done && second_q) begin
         o_rword_hi <= mem.rdata;
      end
   end

   a_no_req_when_busy: assert property (@(posedge clk) disable iff (!rst_x)
      mem.busy |-> !(mem.rd || mem.we));

   a_rd_we_exclusive: assert property (@(posedge clk) disable iff (!rst_x)
      !(mem.rd && mem.we));

   a_pready_pulse: assert property (@(posedge clk) disable iff (!rst_x)
      o_pready |=> !o_pready);

endmodule

//--- logic/load_align.sv
`timescale 1ns/1ns
// load result alignment
module load_align import lsu_pkg::*; (
   input  access_t     i_acc,
   input  logic [31:0] i_rword_lo,
   input  logic [31:0] i_rword_hi,
   output logic [31:0] o_rdata
);

   logic [63:0] pair;
   logic [31:0] shifted;
   logic        sign_b;
   logic        sign_h;

   // two words as one little-endian window
   assign pair = {i_rword_hi, i_rword_lo};

   // first loaded byte down to bit 0
   assign shifted = pair[{i_acc.offset, 3'b000} +: 32];

   assign sign_b = !i_acc.is_unsigned && shifted[7];
   assign sign_h = !i_acc.is_unsigned && shifted[15];

   always_comb begin
      case (i_acc.size)
         SZ_BYTE: begin
            o_rdata = {{24{sign_b}}, shifted[7:0]};
         end
         SZ_HALF: begin
            o_rdata = {{16{sign_h}}, shifted[15:0]};
         end
         default: begin
            o_rdata = shifted;     // full word, no extension
         end
      endcase
   end

endmodule

//--- logic/word_ram.sv
`timescale 1ns/1ns
// word memory model with variable busy time
module word_ram import lsu_pkg::*; (
   input logic        clk,
   input logic        rst_x,
   mem_word_if.memory mem
);

   logic [31:0]       ram_q [RAM_WORDS];
   logic [RAM_CW-1:0] cnt_q;       // busy cycles left
   logic              jitter_q;    // next access runs long
   logic              rd_pend_q;   // read data due at end of busy
   logic [RAM_AW-1:0] raddr_q;

   assign mem.busy = (cnt_q != '0);

   // busy timing
   always_ff @(posedge clk) begin
      if (!rst_x) begin
         cnt_q     <= '0;
         jitter_q  <= 1'b0;
         rd_pend_q <= 1'b0;
      end else if (mem.rd || mem.we) begin
         if (jitter_q) begin
            cnt_q <= RAM_CW'(RAM_LAT + RAM_JITTER);
         end else begin
            cnt_q <= RAM_CW'(RAM_LAT);
         end
         jitter_q  <= !jitter_q;
         rd_pend_q <= mem.rd;
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (mem.we) begin
         for (int i = 0; i < 4; i++) begin
            if (mem.mask[i]) begin
               ram_q[mem.addr][8*i +: 8] <= mem.wdata[8*i +: 8];
            end
         end
      end
      if (mem.rd) begin
         raddr_q <= mem.addr;
      end
      // lands as busy drops, held until the next read
      if (rd_pend_q && (cnt_q == RAM_CW'(1))) begin
         mem.rdata <= ram_q[raddr_q];
      end
   end

   a_req_not_busy: assert property (@(posedge clk) disable iff (!rst_x)
      (mem.rd || mem.we) |-> !mem.busy);

endmodule

//--- logic/lsu_top.sv
`timescale 1ns/1ns
// load/store unit top level
module lsu_top import lsu_pkg::*; (
   input  logic        clk,
   input  logic        rst_x,
   input  logic        i_psel,
   input  logic        i_penable,
   input  logic        i_pwrite,
   input  logic [31:0] i_paddr,
   input  logic [31:0] i_pwdata,
   input  logic [2:0]  i_funct,
   output logic [31:0] o_prdata,
   output logic        o_pready,
   output logic        o_pslverr
);

   access_t     acc;
   access_t     acc_q;
   logic        illegal;
   logic [31:0] rword_lo;
   logic [31:0] rword_hi;

   mem_word_if i_mem_if ();

   access_decode i_access_decode (
      .i_funct   (i_funct),
      .i_addr    (i_paddr),
      .i_wdata   (i_pwdata),
      .o_acc     (acc),
      .o_illegal (illegal)
   );

   access_sequencer i_access_sequencer (
      .clk        (clk),
      .rst_x      (rst_x),
      .i_psel     (i_psel),
      .i_penable  (i_penable),
      .i_pwrite   (i_pwrite),
      .i_acc      (acc),
      .i_illegal  (illegal),
      .o_pready   (o_pready),
      .o_pslverr  (o_pslverr),
      .o_acc_q    (acc_q),
      .o_rword_lo (rword_lo),
      .o_rword_hi (rword_hi),
      .mem        (i_mem_if.sequencer)
   );

   load_align i_load_align (
      .i_acc      (acc_q),
      .i_rword_lo (rword_lo),
      .i_rword_hi (rword_hi),
      .o_rdata    (o_prdata)
   );

   word_ram i_word_ram (
      .clk   (clk),
      .rst_x (rst_x),
      .mem   (i_mem_if.memory)
   );

endmodule

//--- testbench/tb_lsu.sv
`timescale 1ns/1ns
// load/store unit testbench
module tb_lsu import lsu_pkg::*; ();

   localparam int CLK_PERIOD = 40;
   // fill, aligned, split, byte/half, extension, reserved, random
   localparam int N_XFER = 256 + 8 + 12 + 24 + 10 + 10 + 200;
   localparam int WATCHDOG_CYC = N_XFER * (2 * (2 + RAM_LAT + RAM_JITTER) + 4) + 100;

   logic        clk;
   logic        rst_x;
   logic        i_psel;
   logic        i_penable;
   logic        i_pwrite;
   logic [31:0] i_paddr;
   logic [31:0] i_pwdata;
   logic [2:0]  i_funct;
   logic [31:0] o_prdata;
   logic        o_pready;
   logic        o_pslverr;

   logic [7:0]  ref_mem [1024];   // reference byte model
   logic [15:0] lfsr_q;
   int          err_data;
   int          err_flag;

   lsu_top i_lsu_top (
      .clk       (clk),
      .rst_x     (rst_x),
      .i_psel    (i_psel),
      .i_penable (i_penable),
      .i_pwrite  (i_pwrite),
      .i_paddr   (i_paddr),
      .i_pwdata  (i_pwdata),
      .i_funct   (i_funct),
      .o_prdata  (o_prdata),
      .o_pready  (o_pready),
      .o_pslverr (o_pslverr)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
   endtask

   // expected load value, little endian, wraps at 1024
   function automatic logic [31:0] load_ref(input logic [9:0] addr, input logic [2:0] funct);
      logic [31:0] v;
      int          n;
      v = '0;
      n = 1 << funct[1:0];
      for (int i = 0; i < 4; i++) begin
         if (i < n) v[8*i +: 8] = ref_mem[addr + 10'(i)];
      end
      if (!funct[2] && (n == 1)) v = {{24{v[7]}}, v[7:0]};
      if (!funct[2] && (n == 2)) v = {{16{v[15]}}, v[15:0]};
      return v;
   endfunction

   function automatic void store_ref(input logic [9:0] addr, input logic [2:0] funct,
                                     input logic [31:0] data);
      int n;
      n = 1 << funct[1:0];
      for (int i = 0; i < n; i++) begin
         ref_mem[addr + 10'(i)] = data[8*i +: 8];
      end
   endfunction

   task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         err_data++;
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         err_flag++;
         $display("ERROR %s: pslverr expected %b, actual %b", name, exp, act);
      end
   endtask

   // one APB transfer, setup then access until pready
   task automatic apb_access(input logic write, input logic [9:0] addr, input logic [2:0] funct,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      @(negedge clk);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = write;
      i_paddr   = {22'd0, addr};
      i_pwdata  = wdata;
      i_funct   = funct;
      @(negedge clk);
      i_penable = 1'b1;
      while (!o_pready) @(negedge clk);
      rdata = o_prdata;
      err   = o_pslverr;
      @(negedge clk);             // transfer ended at the last rising edge
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   task automatic do_store(input string name, input logic [9:0] addr, input logic [2:0] funct,
                           input logic [31:0] data);
      logic [31:0] rdata;
      logic        err;
      apb_access(1'b1, addr, funct, data, rdata, err);
      check_err(name, 1'b0, err);
      store_ref(addr, funct, data);
   endtask

   task automatic do_load(input string name, input logic [9:0] addr, input logic [2:0] funct,
                          input logic [31:0] exp);
      logic [31:0] rdata;
      logic        err;
      apb_access(1'b0, addr, funct, 32'h0, rdata, err);
      check_err(name, 1'b0, err);
      check_data(name, exp, rdata);
   endtask

   task automatic do_reserved(input string name, input logic write, input logic [2:0] funct);
      logic [31:0] rdata;
      logic        err;
      apb_access(write, 10'd128, funct, 32'hdead_beef, rdata, err);
      check_err(name, 1'b1, err);
   endtask

   // pattern built from every bit of the word index
   task automatic fill_memory();
      logic [7:0] w;
      for (int i = 0; i < 256; i++) begin
         w = 8'(i);
         do_store($sformatf("fill %0d", i), 10'(4 * i), F3_LW,
                  {w ^ 8'h3c, ~w, w + 8'h51, w ^ 8'ha7});
      end
   endtask

   task automatic test_word_aligned();
      logic [9:0] addrs [4];
      addrs = '{10'd0, 10'd4, 10'd300, 10'd1020};
      for (int i = 0; i < 4; i++) do_store("aligned sw", addrs[i], F3_LW, {addrs[i], 22'h2a5f3});
      for (int i = 0; i < 4; i++) do_load("aligned lw", addrs[i], F3_LW, {addrs[i], 22'h2a5f3});
   endtask

   task automatic test_word_split();
      logic [9:0] addr;
      for (int off = 1; off < 4; off++) begin
         addr = 10'(256 + 16 * off + off);
         do_store("split sw", addr, F3_LW, 32'h8070_6050 + 32'h0101_0101 * off);
         do_load("split lw", addr, F3_LW, load_ref(addr, F3_LW));
         do_load("split lbu below", addr - 10'd1, F3_LBU, load_ref(addr - 10'd1, F3_LBU));
         do_load("split lbu above", addr + 10'd4, F3_LBU, load_ref(addr + 10'd4, F3_LBU));
      end
   endtask

   task automatic test_byte_half();
      for (int off = 0; off < 4; off++) begin
         do_store("sb", 10'd512 + 10'(off), F3_LB, 32'h1234_56a0 + 32'(off));
         do_load("sb word 0", 10'd512, F3_LW, load_ref(10'd512, F3_LW));
         do_load("sb word 1", 10'd516, F3_LW, load_ref(10'd516, F3_LW));
         do_store("sh", 10'd528 + 10'(off), F3_LH, 32'h9abc_c3d0 + 32'(off));
         do_load("sh word 0", 10'd528, F3_LW, load_ref(10'd528, F3_LW));
         do_load("sh word 1", 10'd532, F3_LW, load_ref(10'd532, F3_LW));
      end
   endtask

   task automatic test_extension();
      do_store("ext sw neg", 10'd64, F3_LW, 32'h8c7e_f09a);
      do_load("lb neg", 10'd64, F3_LB, 32'hffff_ff9a);
      do_load("lbu neg", 10'd64, F3_LBU, 32'h0000_009a);
      do_load("lh neg", 10'd64, F3_LH, 32'hffff_f09a);
      do_load("lhu neg", 10'd64, F3_LHU, 32'h0000_f09a);
      do_store("ext sw pos", 10'd68, F3_LW, 32'h7e5a_3c21);
      do_load("lb pos", 10'd68, F3_LB, 32'h0000_0021);
      do_load("lbu pos", 10'd68, F3_LBU, 32'h0000_0021);
      do_load("lh pos", 10'd68, F3_LH, 32'h0000_3c21);
      do_load("lhu pos", 10'd68, F3_LHU, 32'h0000_3c21);
   endtask

   task automatic test_reserved();
      do_store("rsv setup", 10'd128, F3_LW, 32'h1234_5678);
      for (int f = 3; f < 8; f++) begin
         if ((f != 4) && (f != 5)) do_reserved($sformatf("rsv load f%0d", f), 1'b0, 3'(f));
         do_reserved($sformatf("rsv store f%0d", f), 1'b1, 3'(f));
      end
      do_load("rsv readback", 10'd128, F3_LW, load_ref(10'd128, F3_LW));
   endtask

   task automatic test_random();
      logic [31:0] r;
      logic        wr;
      logic [1:0]  sz;
      logic        uns;
      logic [9:0]  addr;
      logic [2:0]  funct;
      for (int i = 0; i < 200; i++) begin
         rand_bits(1, r);
         wr = r[0];
         rand_bits(2, r);
         sz = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
         rand_bits(1, r);
         uns = r[0] && !wr && (sz != 2'd2);    // stores and lw have no unsigned form
         rand_bits(10, r);
         addr = r[9:0];
         if ((i % 8) == 0) addr = {8'hff, r[1:0]};   // top word, wraps to word 0
         funct = {uns, sz};
         rand_bits(32, r);
         if (wr) do_store($sformatf("rand %0d store @%0h", i, addr), addr, funct, r);
         else do_load($sformatf("rand %0d load @%0h", i, addr), addr, funct, load_ref(addr, funct));
      end
   endtask

   initial begin
      clk       = 1'b0;
      rst_x     = 1'b0;
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
      i_paddr   = '0;
      i_pwdata  = '0;
      i_funct   = '0;
      lfsr_q    = 16'd35103;
      err_data  = 0;
      err_flag  = 0;
      repeat (5) @(negedge clk);
      rst_x = 1'b1;
      fill_memory();
      test_word_aligned();
      test_word_split();
      test_byte_half();
      test_extension();
      test_reserved();
      test_random();
      $display("data errors: %0d, pslverr errors: %0d", err_data, err_flag);
      if ((err_data + err_flag) == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("timeout: the transfers did not complete in time");
      $display("Done: errors found");
      $finish;
   end

endmodule

//--- lsu.f
logic/lsu_pkg.sv
logic/mem_word_if.sv
logic/access_decode.sv
logic/access_sequencer.sv
logic/load_align.sv
logic/word_ram.sv
logic/lsu_top.sv
testbench/tb_lsu.sv

//--- run.sh
#!/bin/sh
# build and run the load/store unit simulation with Verilator
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -f lsu.f --top-module tb_lsu -o sim_lsu \
   && ./obj_dir/sim_lsu | tee /dev/stderr | grep -qx "Done: no errors" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
